// ==== rtl/fetch_pkg.sv ====
package fetch_pkg;

    // datapath widths
    localparam int xlen        = 32;
    localparam int order_width = 64;
    localparam int beat_width  = 64;
    localparam int line_width  = 256;

    // line geometry, 8 instructions per line
    localparam int beats_per_line   = line_width / beat_width;
    localparam int beat_cnt_bits    = $clog2(beats_per_line);
    localparam int line_offset_bits = 5;
    localparam int tag_width        = xlen - line_offset_bits;

    // first fetch address after reset
    localparam logic [xlen-1:0] reset_pc = 32'haaaaa000;

    // line fill FSM
    typedef enum logic [1:0] {
        fill_idle,
        fill_request,
        fill_beats
    } fill_state_t;

    // fetch control FSM
    typedef enum logic {
        fetch_stream,
        fetch_miss
    } fetch_state_t;

endpackage

// ==== rtl/line_fill.sv ====
`timescale 1ns/10ps

module line_fill (
    input  logic                             clk,
    input  logic                             rst,

    input  logic                             fill_start_i,
    input  logic [fetch_pkg::xlen-1:0]       fill_addr_i,
    output logic                             fill_done_o,
    output logic [fetch_pkg::line_width-1:0] fill_line_o,

    output logic [fetch_pkg::xlen-1:0]       bmem_addr_o,
    output logic                             bmem_read_o,
    input  logic                             bmem_ready_i,
    input  logic [fetch_pkg::beat_width-1:0] bmem_rdata_i,
    input  logic                             bmem_rvalid_i
);

    import fetch_pkg::*;

    fill_state_t              state_q;
    logic [xlen-1:0]          addr_q;
    logic [line_width-1:0]    line_q;
    logic [beat_cnt_bits-1:0] beat_cnt_q;
    logic                     done_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= fill_idle;
            beat_cnt_q <= '0;
            done_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                fill_idle: begin
                    if (fill_start_i) begin
                        state_q <= fill_request;
                    end
                end
                fill_request: begin
                    // request accepted in this cycle
                    if (bmem_ready_i) begin
                        state_q    <= fill_beats;
                        beat_cnt_q <= '0;
                    end
                end
                fill_beats: begin
                    if (bmem_rvalid_i) begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                        if (beat_cnt_q == beat_cnt_bits'(beats_per_line - 1)) begin
                            state_q <= fill_idle;
                            done_q  <= 1'b1;
                        end
                    end
                end
                default: state_q <= fill_idle;
            endcase
        end
    end

    // line aligned address, captured with the start strobe
    always_ff @(posedge clk) begin
        if (state_q == fill_idle && fill_start_i) begin
            addr_q <= {fill_addr_i[xlen-1:line_offset_bits], {line_offset_bits{1'b0}}};
        end
    end

    // beats shift in from the top, beat 0 ends up in the low bits
    always_ff @(posedge clk) begin
        if (state_q == fill_beats && bmem_rvalid_i) begin
            line_q <= {bmem_rdata_i, line_q[line_width-1:beat_width]};
        end
    end

    assign bmem_read_o = (state_q == fill_request);
    assign bmem_addr_o = addr_q;
    assign fill_done_o = done_q;
    assign fill_line_o = line_q;

endmodule

// ==== rtl/inst_queue.sv ====
`timescale 1ns/10ps

module inst_queue #(
    parameter int queue_depth = 16
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              flush_i,

    input  logic                              enq_i,
    input  logic [fetch_pkg::order_width-1:0] enq_order_i,
    input  logic [fetch_pkg::xlen-1:0]        enq_pc_i,
    input  logic [fetch_pkg::xlen-1:0]        enq_inst_i,
    output logic                              full_o,

    input  logic                              deq_i,
    output logic                              empty_o,
    output logic [fetch_pkg::order_width-1:0] deq_order_o,
    output logic [fetch_pkg::xlen-1:0]        deq_pc_o,
    output logic [fetch_pkg::xlen-1:0]        deq_inst_o
);

    import fetch_pkg::*;

    localparam int ptr_bits = $clog2(queue_depth);

    logic [order_width-1:0] order_mem [queue_depth];
    logic [xlen-1:0]        pc_mem    [queue_depth];
    logic [xlen-1:0]        inst_mem  [queue_depth];

    // extra msb tells full from empty
    logic [ptr_bits:0] head_q;
    logic [ptr_bits:0] tail_q;
    logic              do_enq;
    logic              do_deq;

    assign empty_o = (head_q == tail_q);
    assign full_o  = (head_q[ptr_bits] != tail_q[ptr_bits]) &&
                     (head_q[ptr_bits-1:0] == tail_q[ptr_bits-1:0]);

    assign do_enq = enq_i && !full_o && !flush_i;
    assign do_deq = deq_i && !empty_o && !flush_i;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (do_enq) begin
                tail_q <= tail_q + 1'b1;
            end
            if (do_deq) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            order_mem[tail_q[ptr_bits-1:0]] <= enq_order_i;
            pc_mem[tail_q[ptr_bits-1:0]]    <= enq_pc_i;
            inst_mem[tail_q[ptr_bits-1:0]]  <= enq_inst_i;
        end
    end

    // oldest entry
    assign deq_order_o = order_mem[head_q[ptr_bits-1:0]];
    assign deq_pc_o    = pc_mem[head_q[ptr_bits-1:0]];
    assign deq_inst_o  = inst_mem[head_q[ptr_bits-1:0]];

endmodule

// ==== rtl/fetch_ctrl.sv ====
`timescale 1ns/10ps

module fetch_ctrl (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              redirect_i,
    input  logic [fetch_pkg::xlen-1:0]        redirect_pc_i,

    input  logic                              queue_full_i,
    output logic                              enq_o,
    output logic [fetch_pkg::order_width-1:0] enq_order_o,
    output logic [fetch_pkg::xlen-1:0]        enq_pc_o,
    output logic [fetch_pkg::xlen-1:0]        enq_inst_o,

    output logic                              fill_start_o,
    output logic [fetch_pkg::xlen-1:0]        fill_addr_o,
    input  logic                              fill_done_i,
    input  logic [fetch_pkg::line_width-1:0]  fill_line_i
);

    import fetch_pkg::*;

    fetch_state_t           state_q;
    logic [xlen-1:0]        pc_q;
    logic [order_width-1:0] order_q;

    // one line buffer
    logic                   buf_valid_q;
    logic [tag_width-1:0]   buf_tag_q;
    logic [line_width-1:0]  buf_data_q;

    // tag of the line being filled
    logic [tag_width-1:0]   fill_tag_q;

    logic [tag_width-1:0]   pc_tag;
    logic [2:0]             word_idx;
    logic                   line_hit;

    assign pc_tag   = pc_q[xlen-1:line_offset_bits];
    assign word_idx = pc_q[line_offset_bits-1:2];
    assign line_hit = buf_valid_q && (buf_tag_q == pc_tag);

    // enqueue straight out of the buffer, none during redirect
    assign enq_o       = (state_q == fetch_stream) && line_hit &&
                         !queue_full_i && !redirect_i;
    assign enq_order_o = order_q;
    assign enq_pc_o    = pc_q;
    assign enq_inst_o  = buf_data_q[word_idx * xlen +: xlen];

    // miss starts a fill, held back while the queue is full
    assign fill_start_o = (state_q == fetch_stream) && !line_hit &&
                          !queue_full_i && !redirect_i;
    assign fill_addr_o  = pc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= fetch_stream;
            pc_q    <= reset_pc;
            order_q <= '0;
        end else begin
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else if (enq_o) begin
                pc_q    <= pc_q + 32'd4;
                order_q <= order_q + 1'b1;
            end

            case (state_q)
                fetch_stream: begin
                    if (fill_start_o) begin
                        state_q <= fetch_miss;
                    end
                end
                fetch_miss: begin
                    // a redirect does not cancel the fill in flight
                    if (fill_done_i) begin
                        state_q <= fetch_stream;
                    end
                end
                default: state_q <= fetch_stream;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            buf_valid_q <= 1'b0;
        end else if (fill_done_i) begin
            buf_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_start_o) begin
            fill_tag_q <= pc_tag;
        end
        // line stored under the address it was fetched for
        if (fill_done_i) begin
            buf_tag_q  <= fill_tag_q;
            buf_data_q <= fill_line_i;
        end
    end

endmodule

// ==== rtl/fetch_top.sv ====
`timescale 1ns/10ps

module fetch_top #(
    parameter int queue_depth = 16
) (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              redirect_i,
    input  logic [fetch_pkg::xlen-1:0]        redirect_pc_i,

    output logic                              inst_valid_o,
    output logic [fetch_pkg::xlen-1:0]        inst_o,
    output logic [fetch_pkg::xlen-1:0]        inst_pc_o,
    output logic [fetch_pkg::order_width-1:0] inst_order_o,
    input  logic                              inst_take_i,

    output logic [fetch_pkg::xlen-1:0]        bmem_addr_o,
    output logic                              bmem_read_o,
    input  logic                              bmem_ready_i,
    input  logic [fetch_pkg::beat_width-1:0]  bmem_rdata_i,
    input  logic                              bmem_rvalid_i
);

    import fetch_pkg::*;

    logic                   fill_start;
    logic [xlen-1:0]        fill_addr;
    logic                   fill_done;
    logic [line_width-1:0]  fill_line;

    logic                   enq;
    logic [order_width-1:0] enq_order;
    logic [xlen-1:0]        enq_pc;
    logic [xlen-1:0]        enq_inst;
    logic                   queue_full;
    logic                   queue_empty;

    line_fill fill_i (
        .clk           (clk),
        .rst           (rst),
        .fill_start_i  (fill_start),
        .fill_addr_i   (fill_addr),
        .fill_done_o   (fill_done),
        .fill_line_o   (fill_line),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i)
    );

    // redirect also flushes the queue below
    fetch_ctrl ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .queue_full_i  (queue_full),
        .enq_o         (enq),
        .enq_order_o   (enq_order),
        .enq_pc_o      (enq_pc),
        .enq_inst_o    (enq_inst),
        .fill_start_o  (fill_start),
        .fill_addr_o   (fill_addr),
        .fill_done_i   (fill_done),
        .fill_line_i   (fill_line)
    );

    inst_queue #(
        .queue_depth (queue_depth)
    ) queue_i (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (redirect_i),
        .enq_i       (enq),
        .enq_order_i (enq_order),
        .enq_pc_i    (enq_pc),
        .enq_inst_i  (enq_inst),
        .full_o      (queue_full),
        .deq_i       (inst_take_i),
        .empty_o     (queue_empty),
        .deq_order_o (inst_order_o),
        .deq_pc_o    (inst_pc_o),
        .deq_inst_o  (inst_o)
    );

    assign inst_valid_o = !queue_empty;

endmodule

// ==== testbench/fetch_props.sv ====
`timescale 1ns/10ps

module fetch_props #(
    parameter int queue_depth = 16
) (
    input logic                       clk,
    input logic                       rst,
    input logic                       redirect_i,
    input logic                       inst_valid_o,
    input logic [fetch_pkg::xlen-1:0] inst_pc_o,
    input logic                       bmem_read_o,
    input logic [fetch_pkg::xlen-1:0] bmem_addr_o,
    input logic                       bmem_ready_i
);

    // request held with a stable address until ready
    read_held: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o && !bmem_ready_i |=> bmem_read_o && $stable(bmem_addr_o))
        else $error("memory read dropped or address changed before ready");

    flush_empties: assert property (@(posedge clk) disable iff (rst)
        redirect_i |=> !inst_valid_o)
        else $error("queue not empty after redirect");

    pc_aligned: assert property (@(posedge clk) disable iff (rst)
        inst_valid_o |-> inst_pc_o[1:0] == 2'b00)
        else $error("delivered pc not word aligned");

endmodule

bind fetch_top fetch_props #(.queue_depth(queue_depth)) props_i (
    .clk          (clk),
    .rst          (rst),
    .redirect_i   (redirect_i),
    .inst_valid_o (inst_valid_o),
    .inst_pc_o    (inst_pc_o),
    .bmem_read_o  (bmem_read_o),
    .bmem_addr_o  (bmem_addr_o),
    .bmem_ready_i (bmem_ready_i)
);

// ==== testbench/fetch_tb.sv ====
`timescale 1ns/10ps

module fetch_tb;

    import fetch_pkg::*;

    localparam int          clk_half   = 2;
    localparam int          seed       = 91802;
    localparam int          wait_limit = 600;
    localparam logic [31:0] word_key   = 32'h5a5ac3c3;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   redirect;
    logic [xlen-1:0]        redirect_pc;
    logic                   inst_take;
    logic                   inst_valid;
    logic [xlen-1:0]        inst;
    logic [xlen-1:0]        inst_pc;
    logic [order_width-1:0] inst_order;
    logic [xlen-1:0]        bmem_addr;
    logic                   bmem_read;
    logic                   bmem_ready  = 1'b0;
    logic [beat_width-1:0]  bmem_rdata  = '0;
    logic                   bmem_rvalid = 1'b0;

    // memory model state
    int              mem_state;
    int              mem_delay;
    int              mem_beat;
    int              reads_seen = 0;
    logic [xlen-1:0] mem_addr;

    logic [xlen-1:0]        last_pc;
    logic [order_width-1:0] last_order;

    fetch_top #(.queue_depth(16)) dut_i (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .inst_valid_o  (inst_valid),
        .inst_o        (inst),
        .inst_pc_o     (inst_pc),
        .inst_order_o  (inst_order),
        .inst_take_i   (inst_take),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_ready_i  (bmem_ready),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid)
    );

    always #clk_half clk = ~clk;

    // one request at a time with random ready delay and beat gaps
    always @(posedge clk) begin
        bmem_ready  <= 1'b0;
        bmem_rvalid <= 1'b0;
        if (rst) begin
            mem_state <= 0;
        end else if (mem_state == 0 && bmem_read) begin
            mem_state  <= 1;
            mem_delay  <= $urandom_range(0, 5);
            mem_addr   <= bmem_addr;
            reads_seen <= reads_seen + 1;
        end else if (mem_state == 1) begin
            if (mem_delay == 0) begin
                bmem_ready <= 1'b1;
                mem_state  <= 2;
                mem_beat   <= 0;
                mem_delay  <= $urandom_range(0, 5);
            end else begin
                mem_delay <= mem_delay - 1;
            end
        end else if (mem_state == 2) begin
            if (mem_delay == 0) begin
                bmem_rvalid <= 1'b1;
                bmem_rdata  <= {(mem_addr + 8 * mem_beat + 4) ^ word_key,
                                (mem_addr + 8 * mem_beat) ^ word_key};
                mem_beat    <= mem_beat + 1;
                mem_delay   <= $urandom_range(0, 5);
                if (mem_beat == 3) begin
                    mem_state <= 0;
                end
            end else begin
                mem_delay <= mem_delay - 1;
            end
        end
    end

    task automatic fail_with(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got == exp) else begin
            $display("Error: %s got %h expected %h", name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond) else begin
            fail_with(msg);
        end
    endtask

    // take one instruction under a random take pattern
    task automatic take_one(input int take_pct, input logic [31:0] exp_pc,
                            output logic [63:0] order);
        int   waited;
        logic take;
        logic got;
        waited = 0;
        got    = 1'b0;
        while (!got) begin
            @(posedge clk);
            take = ($urandom_range(0, 99) < take_pct);
            inst_take <= take;
            @(negedge clk);
            if (inst_valid && take) begin
                got   = 1'b1;
                order = inst_order;
                check_val("inst_pc_o", inst_pc, exp_pc);
                check_val("inst_o", inst, exp_pc ^ word_key);
            end
            waited++;
            if (waited > wait_limit) begin
                fail_with("no instruction was delivered before the timeout");
            end
        end
        @(posedge clk);
        inst_take <= 1'b0;
    endtask

    task automatic take_next(input int take_pct);
        logic [31:0] exp_pc;
        logic [63:0] order;
        exp_pc = last_pc + 4;
        take_one(take_pct, exp_pc, order);
        check_val("inst_order_o", order, last_order + 1);
        last_pc    = exp_pc;
        last_order = order;
    endtask

    task automatic do_redirect(input logic [31:0] pc);
        @(posedge clk);
        redirect    <= 1'b1;
        redirect_pc <= pc;
        @(posedge clk);
        redirect    <= 1'b0;
    endtask

    // first delivery after a redirect must start at the new pc
    task automatic take_after_redirect(input logic [31:0] pc_exp);
        logic [63:0] order;
        take_one(100, pc_exp, order);
        check_true(order > last_order, "order number did not increase after redirect");
        last_pc    = pc_exp;
        last_order = order;
    endtask

    task automatic wait_mem_idle();
        int waited;
        waited = 0;
        while (mem_state != 0 || bmem_read) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                fail_with("memory read never completed");
            end
        end
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_val("bmem_read_o", bmem_read, 0);
        take_one(100, reset_pc, last_order);
        check_val("inst_order_o", last_order, 0);
        last_pc = reset_pc;
    endtask

    task automatic test_stream();
        // 31 words from a line start cross three line boundaries
        repeat (30) take_next(60);
    endtask

    task automatic test_backpressure();
        int          valid_cycles;
        int          waited;
        logic [31:0] head_pc;
        valid_cycles = 0;
        waited       = 0;
        while (valid_cycles < 40) begin
            @(negedge clk);
            if (inst_valid) begin
                if (valid_cycles == 0) begin
                    head_pc = inst_pc;
                end
                check_val("inst_pc_o", inst_pc, head_pc);
                valid_cycles++;
            end
            waited++;
            if (waited > wait_limit) begin
                fail_with("queue never stayed valid for 40 cycles");
            end
        end
        repeat (24) take_next(100);
    endtask

    task automatic test_redirect();
        logic [31:0] target;
        int          waited;
        repeat (3) take_next(100);
        target = $urandom() & 32'hffff_fffc;
        do_redirect(target);
        take_after_redirect(target);
        repeat (10) take_next(80);
        // next redirect lands while a fill is in flight
        waited = 0;
        while (!bmem_read) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                fail_with("no memory read was seen for the in-flight redirect");
            end
        end
        target = $urandom() & 32'hffff_fffc;
        do_redirect(target);
        take_after_redirect(target);
        repeat (10) take_next(80);
    endtask

    task automatic test_same_line();
        logic [31:0] line;
        logic [31:0] next_line;
        int          reads_before;
        int          waited;
        line         = ($urandom() & 32'hffff_ffe0) ^ 32'h0000_1000;
        next_line    = line + 64;
        reads_before = reads_seen;
        do_redirect(line);
        // this line and the next are filled before the queue is full
        waited = 0;
        while (reads_seen < reads_before + 2) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                fail_with("second line fill was never requested");
            end
        end
        wait_mem_idle();
        do_redirect(line + 32 + 12);
        // first read after the redirect must be for the following line
        waited = 0;
        @(negedge clk);
        while (!bmem_read) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                fail_with("no memory read followed the redirect into the buffered line");
            end
        end
        check_val("bmem_addr_o", bmem_addr, next_line);
        take_after_redirect(line + 32 + 12);
        repeat (4) take_next(100);
    endtask

    initial begin
        void'($urandom(seed));
        rst         = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        inst_take   = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_stream();
        test_backpressure();
        test_redirect();
        test_same_line();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/fetch_pkg.sv
rtl/line_fill.sv
rtl/inst_queue.sv
rtl/fetch_ctrl.sv
rtl/fetch_top.sv
testbench/fetch_props.sv
testbench/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_front

sources:
  - rtl/fetch_pkg.sv
  - rtl/line_fill.sv
  - rtl/inst_queue.sv
  - rtl/fetch_ctrl.sv
  - rtl/fetch_top.sv
  - target: simulation
    files:
      - testbench/fetch_props.sv
      - testbench/fetch_tb.sv
